//--- logic/lane_cfg_pkg.sv
// Lane configuration: instruction slots, operand queues and register file geometry
`default_nettype none

package lane_cfg_pkg;

  // Instructions that can be in flight at once
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned IdWidth = $clog2(NrVInsn);

  // Operand queues, two per functional unit
  localparam int unsigned NrOperandQueues = 4;
  localparam int unsigned AluA = 0;
  localparam int unsigned AluB = 1;
  localparam int unsigned MulA = 2;
  localparam int unsigned MulB = 3;

  // Register file geometry
  localparam int unsigned NrVRegs      = 32;
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);
  localparam int unsigned ElemWidth    = 32;

  // Element counts, full-vector and lane-local
  localparam int unsigned VlWidth = 16;

  // Word address of one element inside the lane's register file
  function automatic int unsigned vrf_addr(input int unsigned vreg, input int unsigned idx,
                                           input int unsigned elems_per_lane);
    return vreg * elems_per_lane + idx;
  endfunction

endpackage

`default_nettype wire

//--- logic/lane_insn_pkg.sv
// Lane instruction types: units, operations, requests, responses and commands
`default_nettype none

package lane_insn_pkg;

  // Target functional unit
  typedef enum logic [0:0] {
    VFU_Alu,
    VFU_Mul
  } vfu_e;

  // Supported integer operations
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL
  } op_e;

  // Request from the main sequencer, counts are for the whole vector
  typedef struct packed {
    logic [lane_cfg_pkg::IdWidth-1:0]      id;
    op_e                                   op;
    vfu_e                                  vfu;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vs1;
    logic                                  use_vs1;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vs2;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vd;
    logic [lane_cfg_pkg::ElemWidth-1:0]    scalar_op;
    logic                                  use_scalar_op;
    logic [lane_cfg_pkg::VlWidth-1:0]      vl;
    logic [lane_cfg_pkg::VlWidth-1:0]      vstart;
    logic [lane_cfg_pkg::NrVInsn-1:0]      hazard_vs1;
    logic [lane_cfg_pkg::NrVInsn-1:0]      hazard_vs2;
    logic [lane_cfg_pkg::NrVInsn-1:0]      vinsn_running;
  } pe_req_t;

  // Finished instructions, one bit per id
  typedef struct packed {
    logic [lane_cfg_pkg::NrVInsn-1:0] vinsn_done;
  } pe_resp_t;

  // One operand queue command, counts are lane-local
  typedef struct packed {
    logic [lane_cfg_pkg::IdWidth-1:0]      id;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vs;
    logic                                  use_vs;
    logic [lane_cfg_pkg::VlWidth-1:0]      vl;
    logic [lane_cfg_pkg::VlWidth-1:0]      vstart;
    logic [lane_cfg_pkg::NrVInsn-1:0]      hazard;
  } operand_cmd_t;

  // Operation handed to one functional unit
  typedef struct packed {
    logic [lane_cfg_pkg::IdWidth-1:0]      id;
    op_e                                   op;
    vfu_e                                  vfu;
    logic [lane_cfg_pkg::VRegIdxWidth-1:0] vd;
    logic [lane_cfg_pkg::ElemWidth-1:0]    scalar_op;
    logic                                  use_scalar_op;
    logic [lane_cfg_pkg::VlWidth-1:0]      vl;
    logic [lane_cfg_pkg::VlWidth-1:0]      vstart;
  } vfu_op_t;

endpackage

`default_nettype wire

//--- logic/operand_cmd_if.sv
// Operand command channel from the lane sequencer to the operand requester
`timescale 1ns/1ps
`default_nettype none

interface operand_cmd_if ();

  // One held command per queue
  lane_insn_pkg::operand_cmd_t [lane_cfg_pkg::NrOperandQueues-1:0] cmd;
  logic [lane_cfg_pkg::NrOperandQueues-1:0] valid;
  // Ready pulse retires the command
  logic [lane_cfg_pkg::NrOperandQueues-1:0] ready;
  // Ids still live in the main sequencer
  logic [lane_cfg_pkg::NrVInsn-1:0]         vinsn_running;

  modport seq (output cmd, output valid, output vinsn_running, input ready);
  modport req (input cmd, input valid, input vinsn_running, output ready);

endinterface

`default_nettype wire

//--- logic/lane_sequencer.sv
// Lane sequencer that splits requests over the lanes and issues unit ops and operand commands
`timescale 1ns/1ps
`default_nettype none

module lane_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic [$clog2(NrLanes)-1:0]   lane_id_i,
  // Main sequencer side
  input  wire lane_insn_pkg::pe_req_t       pe_req_i,
  input  wire logic                         pe_req_valid_i,
  output logic                              pe_req_ready_o,
  output lane_insn_pkg::pe_resp_t           pe_resp_o,
  // Operand requester side
  operand_cmd_if.seq                        cmd_o,
  // Functional units
  output lane_insn_pkg::vfu_op_t            vfu_op_o,
  output logic                              vfu_op_valid_o,
  input  wire logic                         alu_ready_i,
  input  wire logic                         mul_ready_i,
  input  wire logic [lane_cfg_pkg::NrVInsn-1:0] alu_done_i,
  input  wire logic [lane_cfg_pkg::NrVInsn-1:0] mul_done_i
);

  localparam int unsigned LaneIdWidth = $clog2(NrLanes);
  localparam int unsigned NrQ         = lane_cfg_pkg::NrOperandQueues;

  lane_insn_pkg::operand_cmd_t [NrQ-1:0] cmd_new, cmd_d;
  logic [NrQ-1:0] push, cmd_valid_d;

  lane_insn_pkg::vfu_op_t op_d;
  logic                   op_valid_d;

  logic [lane_cfg_pkg::NrVInsn-1:0] running_d, running_q, done_q;
  logic [lane_cfg_pkg::VlWidth-1:0] local_vl, local_vstart;
  int unsigned qa, qb;

  // Share of n elements held by this lane
  function automatic logic [lane_cfg_pkg::VlWidth-1:0] lane_count(
      input logic [lane_cfg_pkg::VlWidth-1:0] n, input logic [LaneIdWidth-1:0] lane);
    return (n >> LaneIdWidth) + lane_cfg_pkg::VlWidth'(lane < n[LaneIdWidth-1:0]);
  endfunction

  // Ready of the unit that runs vfu
  function automatic logic unit_ready(input lane_insn_pkg::vfu_e vfu);
    return (vfu == lane_insn_pkg::VFU_Mul) ? mul_ready_i : alu_ready_i;
  endfunction

  assign cmd_o.vinsn_running = pe_req_i.vinsn_running;
  assign pe_resp_o           = '{vinsn_done: done_q};

  always_comb begin
    local_vl     = lane_count(pe_req_i.vl, lane_id_i);
    local_vstart = lane_count(pe_req_i.vstart, lane_id_i);

    // Queue pair of the target unit
    qa = (pe_req_i.vfu == lane_insn_pkg::VFU_Mul) ? lane_cfg_pkg::MulA : lane_cfg_pkg::AluA;
    qb = (pe_req_i.vfu == lane_insn_pkg::VFU_Mul) ? lane_cfg_pkg::MulB : lane_cfg_pkg::AluB;

    // vs2 is always read while vs1 may give way to the scalar in the unit
    cmd_new     = '0;
    cmd_new[qa] = '{id: pe_req_i.id, vs: pe_req_i.vs1, use_vs: pe_req_i.use_vs1,
                    vl: local_vl, vstart: local_vstart, hazard: pe_req_i.hazard_vs1};
    cmd_new[qb] = '{id: pe_req_i.id, vs: pe_req_i.vs2, use_vs: 1'b1,
                    vl: local_vl, vstart: local_vstart, hazard: pe_req_i.hazard_vs2};

    push           = '0;
    running_d      = running_q & pe_req_i.vinsn_running;
    pe_req_ready_o = 1'b1;

    // Hold the operation until its unit takes it
    op_d       = vfu_op_o;
    op_valid_d = vfu_op_valid_o && !unit_ready(vfu_op_o.vfu);

    if (op_valid_d) begin
      pe_req_ready_o = 1'b0;
    end else if (pe_req_valid_i) begin
      // Busy id or busy queues make the main sequencer retry
      if (running_q[pe_req_i.id] || cmd_o.valid[qa] || cmd_o.valid[qb]) begin
        pe_req_ready_o = 1'b0;
      end else begin
        push[qa]   = 1'b1;
        push[qb]   = 1'b1;
        op_d       = '{id: pe_req_i.id, op: pe_req_i.op, vfu: pe_req_i.vfu, vd: pe_req_i.vd,
                       scalar_op: pe_req_i.scalar_op, use_scalar_op: pe_req_i.use_scalar_op,
                       vl: local_vl, vstart: local_vstart};
        op_valid_d = 1'b1;
        running_d[pe_req_i.id] = 1'b1;
      end
    end

    for (int q = 0; q < NrQ; q++) begin
      cmd_d[q]       = cmd_o.cmd[q];
      cmd_valid_d[q] = cmd_o.valid[q] && !cmd_o.ready[q];
      if (push[q]) begin
        cmd_d[q]       = cmd_new[q];
        cmd_valid_d[q] = 1'b1;
      end
      // Older writers that finished drop out of the hazard mask
      cmd_d[q].hazard = cmd_d[q].hazard & pe_req_i.vinsn_running;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_o.cmd      <= '0;
      cmd_o.valid    <= '0;
      vfu_op_o       <= '0;
      vfu_op_valid_o <= 1'b0;
      running_q      <= '0;
      done_q         <= '0;
    end else begin
      cmd_o.cmd      <= cmd_d;
      cmd_o.valid    <= cmd_valid_d;
      vfu_op_o       <= op_d;
      vfu_op_valid_o <= op_valid_d;
      running_q      <= running_d;
      // Done pulses reach the response one cycle later
      done_q         <= alu_done_i | mul_done_i;
    end
  end

  // Units only finish ids that this lane issued and still holds
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((alu_done_i | mul_done_i) & ~running_q) == '0)
    else $error("done pulse for an id that is not running");

endmodule

`default_nettype wire

//--- logic/operand_requester.sv
// Operand requester: lane register file, per-queue element streaming and write ports
`timescale 1ns/1ps
`default_nettype none

module operand_requester #(
  parameter  int unsigned ElemsPerLane = 8,
  localparam int unsigned AddrWidth    = $clog2(lane_cfg_pkg::NrVRegs * ElemsPerLane),
  localparam int unsigned EW           = lane_cfg_pkg::ElemWidth
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  operand_cmd_if.req                cmd_i,
  // Operand pairs toward the units
  output logic     [EW-1:0]         alu_operand_a_o,
  output logic     [EW-1:0]         alu_operand_b_o,
  output logic                      alu_operand_valid_o,
  input  wire logic                 alu_operand_ready_i,
  output logic     [EW-1:0]         mul_operand_a_o,
  output logic     [EW-1:0]         mul_operand_b_o,
  output logic                      mul_operand_valid_o,
  input  wire logic                 mul_operand_ready_i,
  // Result writes from the units
  input  wire logic                 alu_wr_valid_i,
  input  wire logic [AddrWidth-1:0] alu_wr_addr_i,
  input  wire logic [EW-1:0]        alu_wr_data_i,
  input  wire logic                 mul_wr_valid_i,
  input  wire logic [AddrWidth-1:0] mul_wr_addr_i,
  input  wire logic [EW-1:0]        mul_wr_data_i,
  // Memory unit ports
  input  wire logic                 ld_valid_i,
  input  wire logic [AddrWidth-1:0] ld_addr_i,
  input  wire logic [EW-1:0]        ld_data_i,
  input  wire logic                 st_valid_i,
  input  wire logic [AddrWidth-1:0] st_addr_i,
  output logic     [EW-1:0]         st_data_o,
  output logic                      st_data_valid_o
);

  localparam int unsigned NrQ = lane_cfg_pkg::NrOperandQueues;

  logic [EW-1:0] vrf_q [lane_cfg_pkg::NrVRegs * ElemsPerLane];

  // Elements already streamed, counted from local vstart
  logic [lane_cfg_pkg::VlWidth-1:0] cnt_q [NrQ];
  logic [lane_cfg_pkg::VlWidth-1:0] elem  [NrQ];
  logic [EW-1:0]  rd_data [NrQ];
  logic [NrQ-1:0] clear, pending, step;

  // Unit 0 is the ALU, unit 1 the multiplier
  logic [1:0]    fetch, pair_valid_q;
  logic [EW-1:0] pair_a_q [2];
  logic [EW-1:0] pair_b_q [2];

  always_comb begin
    for (int q = 0; q < NrQ; q++) begin
      elem[q]    = cmd_i.cmd[q].vstart + cnt_q[q];
      // Hazards also drop as soon as the writer leaves vinsn_running
      clear[q]   = cmd_i.valid[q] &&
                   ((cmd_i.cmd[q].hazard & cmd_i.vinsn_running) == '0);
      pending[q] = elem[q] < cmd_i.cmd[q].vl;
      rd_data[q] = cmd_i.cmd[q].use_vs ?
                   vrf_q[AddrWidth'(lane_cfg_pkg::vrf_addr(cmd_i.cmd[q].vs, elem[q],
                                                           ElemsPerLane))] : '0;
      // Retire once every element has gone out
      cmd_i.ready[q] = clear[q] && !pending[q];
    end

    // A store read takes the read port for this cycle
    fetch[0] = clear[lane_cfg_pkg::AluA] && clear[lane_cfg_pkg::AluB] &&
               pending[lane_cfg_pkg::AluA] && pending[lane_cfg_pkg::AluB] &&
               !st_valid_i && (!pair_valid_q[0] || alu_operand_ready_i);
    fetch[1] = clear[lane_cfg_pkg::MulA] && clear[lane_cfg_pkg::MulB] &&
               pending[lane_cfg_pkg::MulA] && pending[lane_cfg_pkg::MulB] &&
               !st_valid_i && (!pair_valid_q[1] || mul_operand_ready_i);

    step[lane_cfg_pkg::AluA] = fetch[0];
    step[lane_cfg_pkg::AluB] = fetch[0];
    step[lane_cfg_pkg::MulA] = fetch[1];
    step[lane_cfg_pkg::MulB] = fetch[1];
  end

  assign alu_operand_a_o     = pair_a_q[0];
  assign alu_operand_b_o     = pair_b_q[0];
  assign alu_operand_valid_o = pair_valid_q[0];
  assign mul_operand_a_o     = pair_a_q[1];
  assign mul_operand_b_o     = pair_b_q[1];
  assign mul_operand_valid_o = pair_valid_q[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int q = 0; q < NrQ; q++) begin
        cnt_q[q] <= '0;
      end
      pair_valid_q    <= '0;
      st_data_valid_o <= 1'b0;
    end else begin
      for (int q = 0; q < NrQ; q++) begin
        if (cmd_i.ready[q]) begin
          cnt_q[q] <= '0;
        end else if (step[q]) begin
          cnt_q[q] <= cnt_q[q] + 1'b1;
        end
      end
      if (fetch[0]) begin
        pair_valid_q[0] <= 1'b1;
      end else if (alu_operand_ready_i) begin
        pair_valid_q[0] <= 1'b0;
      end
      if (fetch[1]) begin
        pair_valid_q[1] <= 1'b1;
      end else if (mul_operand_ready_i) begin
        pair_valid_q[1] <= 1'b0;
      end
      st_data_valid_o <= st_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    // Later writes win: load over ALU over multiplier
    if (mul_wr_valid_i) begin
      vrf_q[mul_wr_addr_i] <= mul_wr_data_i;
    end
    if (alu_wr_valid_i) begin
      vrf_q[alu_wr_addr_i] <= alu_wr_data_i;
    end
    if (ld_valid_i) begin
      vrf_q[ld_addr_i] <= ld_data_i;
    end
    if (st_valid_i) begin
      st_data_o <= vrf_q[st_addr_i];
    end
    if (fetch[0]) begin
      pair_a_q[0] <= rd_data[lane_cfg_pkg::AluA];
      pair_b_q[0] <= rd_data[lane_cfg_pkg::AluB];
    end
    if (fetch[1]) begin
      pair_a_q[1] <= rd_data[lane_cfg_pkg::MulA];
      pair_b_q[1] <= rd_data[lane_cfg_pkg::MulB];
    end
  end

  // Units and the load port never target one element in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ld_valid_i && alu_wr_valid_i && ld_addr_i == alu_wr_addr_i) &&
    !(ld_valid_i && mul_wr_valid_i && ld_addr_i == mul_wr_addr_i) &&
    !(alu_wr_valid_i && mul_wr_valid_i && alu_wr_addr_i == mul_wr_addr_i))
    else $error("two register file writes to one address");

endmodule

`default_nettype wire

//--- logic/lane_vfu.sv
// Lane functional unit taking one element per cycle with result write-back and done pulse
`timescale 1ns/1ps
`default_nettype none

module lane_vfu #(
  parameter  int unsigned ElemsPerLane = 8,
  localparam int unsigned AddrWidth    = $clog2(lane_cfg_pkg::NrVRegs * ElemsPerLane),
  localparam int unsigned EW           = lane_cfg_pkg::ElemWidth
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire lane_insn_pkg::vfu_op_t op_i,
  input  wire logic                   op_valid_i,
  output logic                        op_ready_o,
  input  wire logic [EW-1:0]          operand_a_i,
  input  wire logic [EW-1:0]          operand_b_i,
  input  wire logic                   operand_valid_i,
  output logic                        operand_ready_o,
  output logic                        wr_valid_o,
  output logic     [AddrWidth-1:0]    wr_addr_o,
  output logic     [EW-1:0]           wr_data_o,
  output logic [lane_cfg_pkg::NrVInsn-1:0] done_o
);

  lane_insn_pkg::vfu_op_t           op_q;
  logic                             busy_q;
  logic [lane_cfg_pkg::VlWidth-1:0] idx_q;
  logic                             finish, take, accept;
  logic [EW-1:0]                    opa, result;

  // Last element taken or nothing to do
  assign finish          = busy_q && (idx_q >= op_q.vl);
  assign op_ready_o      = !busy_q || finish;
  assign accept          = op_valid_i && op_ready_o;
  assign operand_ready_o = busy_q && !finish;
  assign take            = operand_valid_i && operand_ready_o;

  always_comb begin
    // Scalar takes the place of vs1
    opa = op_q.use_scalar_op ? op_q.scalar_op : operand_a_i;
    case (op_q.op)
      lane_insn_pkg::OP_ADD: result = operand_b_i + opa;
      // vs2 minus vs1
      lane_insn_pkg::OP_SUB: result = operand_b_i - opa;
      lane_insn_pkg::OP_AND: result = operand_b_i & opa;
      lane_insn_pkg::OP_OR:  result = operand_b_i | opa;
      lane_insn_pkg::OP_XOR: result = operand_b_i ^ opa;
      lane_insn_pkg::OP_MUL: result = operand_b_i * opa;
      default:               result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      idx_q      <= '0;
      wr_valid_o <= 1'b0;
      done_o     <= '0;
    end else begin
      wr_valid_o <= take;
      // Done lines up with the last write
      done_o     <= finish ? (lane_cfg_pkg::NrVInsn'(1) << op_q.id) : '0;
      if (accept) begin
        busy_q <= 1'b1;
        idx_q  <= op_i.vstart;
      end else if (finish) begin
        busy_q <= 1'b0;
      end else if (take) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= op_i;
    end
    if (take) begin
      wr_addr_o <= AddrWidth'(lane_cfg_pkg::vrf_addr(op_q.vd, idx_q, ElemsPerLane));
      wr_data_o <= result;
    end
  end

endmodule

`default_nettype wire

//--- logic/vector_lane.sv
// Vector lane top joining sequencer, operand requester, ALU and multiplier
`timescale 1ns/1ps
`default_nettype none

module vector_lane #(
  parameter  int unsigned NrLanes      = 4,
  parameter  int unsigned ElemsPerLane = 8,
  localparam int unsigned AddrWidth    = $clog2(lane_cfg_pkg::NrVRegs * ElemsPerLane),
  localparam int unsigned EW           = lane_cfg_pkg::ElemWidth
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic [$clog2(NrLanes)-1:0] lane_id_i,
  input  wire lane_insn_pkg::pe_req_t     pe_req_i,
  input  wire logic                       pe_req_valid_i,
  output logic                            pe_req_ready_o,
  output lane_insn_pkg::pe_resp_t         pe_resp_o,
  input  wire logic                       ld_valid_i,
  input  wire logic [AddrWidth-1:0]       ld_addr_i,
  input  wire logic [EW-1:0]              ld_data_i,
  input  wire logic                       st_valid_i,
  input  wire logic [AddrWidth-1:0]       st_addr_i,
  output logic     [EW-1:0]               st_data_o,
  output logic                            st_data_valid_o
);

  lane_insn_pkg::vfu_op_t vfu_op;
  logic vfu_op_valid, alu_op_ready, mul_op_ready;
  logic [lane_cfg_pkg::NrVInsn-1:0] alu_done, mul_done;
  logic [EW-1:0] alu_a, alu_b, mul_a, mul_b, alu_wr_data, mul_wr_data;
  logic alu_opnd_valid, alu_opnd_ready, mul_opnd_valid, mul_opnd_ready;
  logic alu_wr_valid, mul_wr_valid;
  logic [AddrWidth-1:0] alu_wr_addr, mul_wr_addr;

  operand_cmd_if cmd_if ();

  lane_sequencer #(.NrLanes(NrLanes)) seq_i (
    .clk_i, .rst_ni, .lane_id_i, .pe_req_i, .pe_req_valid_i, .pe_req_ready_o, .pe_resp_o,
    .cmd_o(cmd_if.seq), .vfu_op_o(vfu_op), .vfu_op_valid_o(vfu_op_valid),
    .alu_ready_i(alu_op_ready), .mul_ready_i(mul_op_ready),
    .alu_done_i(alu_done), .mul_done_i(mul_done)
  );

  operand_requester #(.ElemsPerLane(ElemsPerLane)) req_i (
    .clk_i, .rst_ni, .cmd_i(cmd_if.req),
    .alu_operand_a_o(alu_a), .alu_operand_b_o(alu_b),
    .alu_operand_valid_o(alu_opnd_valid), .alu_operand_ready_i(alu_opnd_ready),
    .mul_operand_a_o(mul_a), .mul_operand_b_o(mul_b),
    .mul_operand_valid_o(mul_opnd_valid), .mul_operand_ready_i(mul_opnd_ready),
    .alu_wr_valid_i(alu_wr_valid), .alu_wr_addr_i(alu_wr_addr), .alu_wr_data_i(alu_wr_data),
    .mul_wr_valid_i(mul_wr_valid), .mul_wr_addr_i(mul_wr_addr), .mul_wr_data_i(mul_wr_data),
    .ld_valid_i, .ld_addr_i, .ld_data_i, .st_valid_i, .st_addr_i, .st_data_o, .st_data_valid_o
  );

  // The held operation is offered only to its own unit
  lane_vfu #(.ElemsPerLane(ElemsPerLane)) alu_i (
    .clk_i, .rst_ni, .op_i(vfu_op),
    .op_valid_i(vfu_op_valid && vfu_op.vfu == lane_insn_pkg::VFU_Alu), .op_ready_o(alu_op_ready),
    .operand_a_i(alu_a), .operand_b_i(alu_b),
    .operand_valid_i(alu_opnd_valid), .operand_ready_o(alu_opnd_ready),
    .wr_valid_o(alu_wr_valid), .wr_addr_o(alu_wr_addr), .wr_data_o(alu_wr_data),
    .done_o(alu_done)
  );

  lane_vfu #(.ElemsPerLane(ElemsPerLane)) mul_i (
    .clk_i, .rst_ni, .op_i(vfu_op),
    .op_valid_i(vfu_op_valid && vfu_op.vfu == lane_insn_pkg::VFU_Mul), .op_ready_o(mul_op_ready),
    .operand_a_i(mul_a), .operand_b_i(mul_b),
    .operand_valid_i(mul_opnd_valid), .operand_ready_o(mul_opnd_ready),
    .wr_valid_o(mul_wr_valid), .wr_addr_o(mul_wr_addr), .wr_data_o(mul_wr_data),
    .done_o(mul_done)
  );

endmodule

`default_nettype wire

//--- tests/tb_vector_lane.sv
// Directed testbench for the vector lane acting as main sequencer and memory unit
`timescale 1ns/1ps
`default_nettype none

module tb_vector_lane;

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned Epl       = 8;
  localparam int unsigned LaneId    = 1;
  localparam int unsigned NrVRegs   = lane_cfg_pkg::NrVRegs;
  localparam int unsigned AddrWidth = $clog2(NrVRegs * Epl);
  localparam time         ClkPeriod = 40ns;
  localparam int          Timeout   = 200;

  logic                     clk;
  logic                     rst_n;
  logic [1:0]               lane_id;
  lane_insn_pkg::pe_req_t   pe_req;
  logic                     pe_req_valid;
  logic                     pe_req_ready;
  lane_insn_pkg::pe_resp_t  pe_resp;
  logic                     ld_valid;
  logic [AddrWidth-1:0]     ld_addr;
  logic [31:0]              ld_data;
  logic                     st_valid;
  logic [AddrWidth-1:0]     st_addr;
  logic [31:0]              st_data;
  logic                     st_data_valid;

  // Register file model, live ids and sticky done bits
  logic [31:0] mdl [NrVRegs * Epl];
  logic [7:0]  running   = '0;
  logic [7:0]  done_seen = '0;
  integer      seed      = 32'h7085;
  int          checks    = 0;
  int          mismatches = 0;
  int          timeouts  = 0;

  vector_lane #(.NrLanes(NrLanes), .ElemsPerLane(Epl)) vector_lane_i (
    .clk_i(clk), .rst_ni(rst_n), .lane_id_i(lane_id),
    .pe_req_i(pe_req), .pe_req_valid_i(pe_req_valid), .pe_req_ready_o(pe_req_ready),
    .pe_resp_o(pe_resp),
    .ld_valid_i(ld_valid), .ld_addr_i(ld_addr), .ld_data_i(ld_data),
    .st_valid_i(st_valid), .st_addr_i(st_addr),
    .st_data_o(st_data), .st_data_valid_o(st_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // One-cycle done pulses collected in the low phase
  always @(negedge clk) begin
    if (rst_n) begin
      done_seen = done_seen | pe_resp.vinsn_done;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Expected result with vs2 as operand b and vs1 or the scalar as operand a
  function automatic logic [31:0] ref_result(input lane_insn_pkg::op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    case (op)
      lane_insn_pkg::OP_ADD: return b + a;
      lane_insn_pkg::OP_SUB: return b - a;
      lane_insn_pkg::OP_AND: return b & a;
      lane_insn_pkg::OP_OR:  return b | a;
      lane_insn_pkg::OP_XOR: return b ^ a;
      default:               return b * a;
    endcase
  endfunction

  function automatic lane_insn_pkg::pe_req_t make_req(
      input int id, input lane_insn_pkg::op_e op, input int vs1, input int vs2, input int vd,
      input logic [31:0] scalar, input bit use_scalar, input int vl, input int vstart,
      input logic [7:0] hazard_vs1);
    lane_insn_pkg::pe_req_t r;
    r               = '0;
    r.id            = lane_cfg_pkg::IdWidth'(id);
    r.op            = op;
    // Multiply runs on the second unit
    r.vfu           = (op == lane_insn_pkg::OP_MUL) ? lane_insn_pkg::VFU_Mul :
                                                      lane_insn_pkg::VFU_Alu;
    r.vs1           = lane_cfg_pkg::VRegIdxWidth'(vs1);
    r.use_vs1       = !use_scalar;
    r.vs2           = lane_cfg_pkg::VRegIdxWidth'(vs2);
    r.vd            = lane_cfg_pkg::VRegIdxWidth'(vd);
    r.scalar_op     = scalar;
    r.use_scalar_op = use_scalar;
    r.vl            = lane_cfg_pkg::VlWidth'(vl);
    r.vstart        = lane_cfg_pkg::VlWidth'(vstart);
    r.hazard_vs1    = hazard_vs1;
    return r;
  endfunction

  // Element e sits in lane e mod NrLanes at local index e div NrLanes
  task automatic apply_model(input lane_insn_pkg::pe_req_t r);
    int          e;
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < Epl; i++) begin
      e = i * NrLanes + LaneId;
      if (e >= r.vstart && e < r.vl) begin
        if (r.use_scalar_op) begin
          a = r.scalar_op;
        end else if (r.use_vs1) begin
          a = mdl[r.vs1 * Epl + i];
        end else begin
          a = '0;
        end
        b = mdl[r.vs2 * Epl + i];
        mdl[r.vd * Epl + i] = ref_result(r.op, a, b);
      end
    end
  endtask

  task automatic load_regs();
    for (int addr = 0; addr < NrVRegs * Epl; addr++) begin
      ld_valid  = 1'b1;
      ld_addr   = AddrWidth'(addr);
      ld_data   = $random(seed);
      mdl[addr] = ld_data;
      @(negedge clk);
    end
    ld_valid = 1'b0;
  endtask

  task automatic read_elem(input int addr, output logic [31:0] data);
    int t;
    st_valid = 1'b1;
    st_addr  = AddrWidth'(addr);
    @(negedge clk);
    st_valid = 1'b0;
    t = 0;
    while (!st_data_valid && t < Timeout) begin
      @(negedge clk);
      t++;
    end
    if (!st_data_valid) begin
      timeouts++;
      $display("store read of address %0d never returned data", addr);
    end
    data = st_data;
  endtask

  task automatic check_vreg(input string test, input int vreg);
    logic [31:0] data;
    for (int i = 0; i < Epl; i++) begin
      read_elem(vreg * Epl + i, data);
      check_val($sformatf("%s v%0d[%0d]", test, vreg, i), mdl[vreg * Epl + i], data);
    end
  endtask

  // Holds the request until a transfer or until max_cycles refusals
  task automatic try_issue(input lane_insn_pkg::pe_req_t r, input int max_cycles,
                           output bit accepted, output int refused);
    accepted             = 1'b0;
    refused              = 0;
    pe_req               = r;
    pe_req.vinsn_running = running;
    pe_req_valid         = 1'b1;
    while (!accepted && refused < max_cycles) begin
      // Ready has settled by the middle of the low phase
      #(ClkPeriod / 4);
      accepted = pe_req_ready;
      @(negedge clk);
      if (!accepted) begin
        refused++;
      end
    end
    pe_req_valid = 1'b0;
    if (accepted) begin
      running[r.id]        = 1'b1;
      pe_req.vinsn_running = running;
    end
  endtask

  task automatic issue(input lane_insn_pkg::pe_req_t r, input string test);
    bit acc;
    int n;
    try_issue(r, Timeout, acc, n);
    if (!acc) begin
      timeouts++;
      $display("request with id %0d was never accepted in %s", r.id, test);
    end
  endtask

  // Waits for the done bit and then drops the id from vinsn_running
  task automatic wait_and_retire(input int id, input string test);
    int t;
    t = 0;
    while (!done_seen[id] && t < Timeout) begin
      @(negedge clk);
      t++;
    end
    if (done_seen[id]) begin
      done_seen[id] = 1'b0;
    end else begin
      timeouts++;
      $display("done bit of id %0d never arrived in %s", id, test);
    end
    running[id]          = 1'b0;
    pe_req.vinsn_running = running;
  endtask

  task automatic reset_state_test();
    #(ClkPeriod / 4);
    check_val("reset_state pe_req_ready_o", 32'd1, 32'(pe_req_ready));
    check_val("reset_state vinsn_done", 32'd0, 32'(pe_resp.vinsn_done));
    check_val("reset_state st_data_valid_o", 32'd0, 32'(st_data_valid));
    @(negedge clk);
  endtask

  task automatic alu_ops_test();
    lane_insn_pkg::op_e     ops [5];
    lane_insn_pkg::pe_req_t r;
    ops = '{lane_insn_pkg::OP_ADD, lane_insn_pkg::OP_SUB, lane_insn_pkg::OP_AND,
            lane_insn_pkg::OP_OR, lane_insn_pkg::OP_XOR};
    for (int k = 0; k < 5; k++) begin
      r = make_req(k, ops[k], 1, 2, 3 + k, '0, 1'b0, 32, 0, '0);
      issue(r, "alu_ops");
      wait_and_retire(k, "alu_ops");
      apply_model(r);
      check_vreg("alu_ops", 3 + k);
    end
  endtask

  task automatic lane_split_test();
    lane_insn_pkg::pe_req_t r;
    // Three local elements while the rest of v12 stays
    r = make_req(0, lane_insn_pkg::OP_ADD, 8, 9, 12, '0, 1'b0, 10, 0, '0);
    issue(r, "lane_split");
    wait_and_retire(0, "lane_split");
    apply_model(r);
    check_vreg("lane_split", 12);
    // Local elements 0 and 1 fall below vstart
    r = make_req(1, lane_insn_pkg::OP_SUB, 8, 9, 13, '0, 1'b0, 32, 6, '0);
    issue(r, "lane_split");
    wait_and_retire(1, "lane_split");
    apply_model(r);
    check_vreg("lane_split", 13);
  endtask

  task automatic mul_scalar_test();
    lane_insn_pkg::pe_req_t r;
    logic [31:0]            scalar;
    scalar = $random(seed);
    r = make_req(3, lane_insn_pkg::OP_MUL, 0, 14, 15, scalar, 1'b1, 32, 0, '0);
    issue(r, "mul_scalar");
    wait_and_retire(3, "mul_scalar");
    apply_model(r);
    check_vreg("mul_scalar", 15);
  endtask

  task automatic hazard_test();
    lane_insn_pkg::pe_req_t mul_r;
    lane_insn_pkg::pe_req_t add_r;
    lane_insn_pkg::pe_req_t reuse_r;
    bit                     acc;
    int                     n;
    mul_r = make_req(1, lane_insn_pkg::OP_MUL, 16, 17, 18, '0, 1'b0, 32, 0, '0);
    // Reads v18 while the multiply still owns it
    add_r = make_req(2, lane_insn_pkg::OP_ADD, 18, 19, 22, '0, 1'b0, 32, 0, 8'b0000_0010);
    // Same id as the first multiply on queues that drain long before that id is freed
    reuse_r = make_req(1, lane_insn_pkg::OP_MUL, 19, 20, 21, '0, 1'b0, 32, 0, '0);
    issue(mul_r, "hazard");
    // Issued at once so v18 would be read before the multiply writes it
    issue(add_r, "hazard");
    try_issue(reuse_r, 20, acc, n);
    check_val("hazard busy id refused", 32'd0, 32'(acc));
    wait_and_retire(1, "hazard");
    wait_and_retire(2, "hazard");
    apply_model(mul_r);
    apply_model(add_r);
    check_vreg("hazard", 18);
    check_vreg("hazard", 22);
    // Id 1 is free again
    issue(reuse_r, "hazard");
    wait_and_retire(1, "hazard");
    apply_model(reuse_r);
    check_vreg("hazard", 21);
  endtask

  task automatic back_pressure_test();
    lane_insn_pkg::pe_req_t r1;
    lane_insn_pkg::pe_req_t r2;
    bit                     acc;
    int                     n;
    r1 = make_req(4, lane_insn_pkg::OP_OR, 23, 24, 25, '0, 1'b0, 32, 0, '0);
    r2 = make_req(5, lane_insn_pkg::OP_AND, 24, 26, 27, '0, 1'b0, 32, 0, '0);
    issue(r1, "back_pressure");
    try_issue(r2, Timeout, acc, n);
    check_val("back_pressure second accepted", 32'd1, 32'(acc));
    check_val("back_pressure second held back", 32'd1, 32'(n > 0));
    wait_and_retire(4, "back_pressure");
    wait_and_retire(5, "back_pressure");
    apply_model(r1);
    apply_model(r2);
    check_vreg("back_pressure", 25);
    check_vreg("back_pressure", 27);
  endtask

  task automatic zero_length_test();
    lane_insn_pkg::pe_req_t r;
    // Element 0 lives in lane 0 so nothing lands here
    r = make_req(6, lane_insn_pkg::OP_ADD, 28, 29, 30, '0, 1'b0, 1, 0, '0);
    issue(r, "zero_length");
    wait_and_retire(6, "zero_length");
    apply_model(r);
    check_vreg("zero_length", 30);
  endtask

  initial begin
    rst_n        = 1'b0;
    lane_id      = 2'(LaneId);
    pe_req       = '0;
    pe_req_valid = 1'b0;
    ld_valid     = 1'b0;
    ld_addr      = '0;
    ld_data      = '0;
    st_valid     = 1'b0;
    st_addr      = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    load_regs();
    alu_ops_test();
    lane_split_test();
    mul_scalar_test();
    hazard_test();
    back_pressure_test();
    zero_length_test();

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vector_lane.f
logic/lane_cfg_pkg.sv
logic/lane_insn_pkg.sv
logic/operand_cmd_if.sv
logic/lane_sequencer.sv
logic/operand_requester.sv
logic/lane_vfu.sv
logic/vector_lane.sv
tests/tb_vector_lane.sv
